/* Bender.yml */
package:
  name: ic_mem

sources:
  # RTL, compile order
  - include_dirs:
      - verilog
    files:
      - verilog/ic_mem_pkg.sv
      - verilog/ic_scr_key_mgr.sv
      - verilog/ic_ram_bank.sv
      - verilog/core_clock_ctrl.sv
      - verilog/ic_mem_top.sv

  # Testbench, top module ic_mem_tb
  - target: test
    include_dirs:
      - verilog
    files:
      - verif/ic_mem_tb.sv

/* ic_mem.f */
+incdir+verilog
verilog/ic_mem_pkg.sv
verilog/ic_scr_key_mgr.sv
verilog/ic_ram_bank.sv
verilog/core_clock_ctrl.sv
verilog/ic_mem_top.sv
verif/ic_mem_tb.sv

/* verif/ic_mem_tb.sv */
// Instruction-cache memory testbench
// Random bank traffic, rekeying and clock control against a reference model
// Concurrent checks compare every DUT output with the model

`default_nettype none

`include "ic_mem_settings.svh"

module ic_mem_tb import ic_mem_pkg::*; ();

  localparam int wait_limit = 50;

  logic                               clk_i;
  logic                               rst_ni;
  logic                               test_en_i;
  busy_mubi_t                         core_busy_i;
  logic                               debug_req_i;
  logic                               irq_pending_i;
  logic                               irq_nm_i;
  logic                               core_clk_o;
  logic                               core_sleep_o;
  logic                               ic_scr_key_req_i;
  logic                               scramble_key_valid_i;
  scr_key_t                           scramble_key_i;
  scr_nonce_t                         scramble_nonce_i;
  logic                               scramble_req_o;
  logic                               ic_scr_key_valid_o;
  logic [`IC_NUM_WAYS-1:0]            ic_tag_req_i;
  logic                               ic_tag_write_i;
  ic_index_t                          ic_tag_addr_i;
  ic_tag_t                            ic_tag_wdata_i;
  ic_tag_t  [`IC_NUM_WAYS-1:0]        ic_tag_rdata_o;
  logic [`IC_NUM_WAYS-1:0]            ic_data_req_i;
  logic                               ic_data_write_i;
  ic_index_t                          ic_data_addr_i;
  ic_line_t                           ic_data_wdata_i;
  ic_line_t [`IC_NUM_WAYS-1:0]        ic_data_rdata_o;

  // Reference model state
  ic_tag_t    exp_tag_mem   [`IC_NUM_WAYS][`IC_NUM_LINES];
  ic_line_t   exp_line_mem  [`IC_NUM_WAYS][`IC_NUM_LINES];
  ic_tag_t    exp_tag_rdata [`IC_NUM_WAYS];
  ic_line_t   exp_line_rdata[`IC_NUM_WAYS];
  scr_key_t   exp_key;
  scr_nonce_t exp_nonce;
  logic       exp_req;
  logic       exp_valid;
  busy_mubi_t exp_busy;
  logic       exp_sleep;
  logic       exp_gate;

  string test_name;
  int    error_count;
  int    read_count;
  int    rekey_count;

  ic_mem_top i_dut (
    .clk_i, .rst_ni, .test_en_i,
    .core_busy_i, .debug_req_i, .irq_pending_i, .irq_nm_i,
    .core_clk_o, .core_sleep_o,
    .ic_scr_key_req_i, .scramble_key_valid_i, .scramble_key_i, .scramble_nonce_i,
    .scramble_req_o, .ic_scr_key_valid_o,
    .ic_tag_req_i, .ic_tag_write_i, .ic_tag_addr_i, .ic_tag_wdata_i, .ic_tag_rdata_o,
    .ic_data_req_i, .ic_data_write_i, .ic_data_addr_i, .ic_data_wdata_i, .ic_data_rdata_o
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Wake-up is any busy pattern but off, or any wake-up source
  assign exp_sleep = !((exp_busy != `MUBI_OFF) || debug_req_i || irq_pending_i || irq_nm_i);

  always @(posedge clk_i or negedge rst_ni) begin : model
    logic [2*`IC_SCR_KEY_W-1:0] stream;
    ic_index_t                  tag_phys;
    ic_index_t                  line_phys;
    // Key repeated twice covers the widest payload, narrower ones keep the low bits
    stream    = {exp_key, exp_key};
    tag_phys  = ic_tag_addr_i ^ exp_nonce;
    line_phys = ic_data_addr_i ^ exp_nonce;
    if (!rst_ni) begin
      exp_req   <= 1'b0;
      exp_valid <= 1'b1;
      exp_key   <= `IC_SCR_KEY_DEFAULT;
      exp_nonce <= `IC_SCR_NONCE_DEFAULT;
      exp_busy  <= `MUBI_OFF;
      for (int w = 0; w < `IC_NUM_WAYS; w++) begin
        exp_tag_rdata[w]  <= '0;
        exp_line_rdata[w] <= '0;
      end
    end else begin
      if (exp_req && scramble_key_valid_i) begin
        exp_req   <= 1'b0;
        exp_valid <= 1'b1;
      end else if (!exp_req && ic_scr_key_req_i) begin
        exp_req   <= 1'b1;
        exp_valid <= 1'b0;
      end
      if (scramble_key_valid_i) begin
        exp_key   <= scramble_key_i;
        exp_nonce <= scramble_nonce_i;
      end
      exp_busy <= core_busy_i;
      for (int w = 0; w < `IC_NUM_WAYS; w++) begin
        if (ic_tag_req_i[w] && exp_valid) begin
          if (ic_tag_write_i) exp_tag_mem[w][tag_phys] <= ic_tag_wdata_i ^ stream[`IC_TAG_W-1:0];
          else exp_tag_rdata[w] <= exp_tag_mem[w][tag_phys] ^ stream[`IC_TAG_W-1:0];
        end
        if (ic_data_req_i[w] && exp_valid) begin
          if (ic_data_write_i) exp_line_mem[w][line_phys] <= ic_data_wdata_i ^ stream;
          else exp_line_rdata[w] <= exp_line_mem[w][line_phys] ^ stream;
        end
      end
    end
  end

  // Gate level for the coming high phase
  always @(posedge clk_i) begin
    exp_gate <= !exp_sleep || test_en_i;
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  req_flag_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    scramble_req_o === exp_req)
  else begin
    error_count++;
    $display("Mismatch in %s: scramble_req_o expected %b, got %b",
             test_name, $sampled(exp_req), $sampled(scramble_req_o));
  end

  key_valid_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ic_scr_key_valid_o === exp_valid)
  else begin
    error_count++;
    $display("Mismatch in %s: ic_scr_key_valid_o expected %b, got %b",
             test_name, $sampled(exp_valid), $sampled(ic_scr_key_valid_o));
  end

  sleep_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    core_sleep_o === exp_sleep)
  else begin
    error_count++;
    $display("Mismatch in %s: core_sleep_o expected %b, got %b",
             test_name, $sampled(exp_sleep), $sampled(core_sleep_o));
  end

  // Sampled in the high phase, where the gated clock shows the latch
  gated_clk_a : assert property (@(negedge clk_i) disable iff (!rst_ni)
    core_clk_o === exp_gate)
  else begin
    error_count++;
    $display("Mismatch in %s: core_clk_o expected %b, got %b",
             test_name, $sampled(exp_gate), $sampled(core_clk_o));
  end

  // Gated clock stays low through the low phase
  gated_clk_low_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    core_clk_o === 1'b0)
  else begin
    error_count++;
    $display("Mismatch in %s: core_clk_o in low phase expected 0, got %b",
             test_name, $sampled(core_clk_o));
  end

  for (genvar w = 0; w < `IC_NUM_WAYS; w++) begin : g_rdata_checks
    tag_rdata_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
      ic_tag_rdata_o[w] === exp_tag_rdata[w])
    else begin
      error_count++;
      $display("Mismatch in %s: way %0d tag expected %h, got %h",
               test_name, w, $sampled(exp_tag_rdata[w]), $sampled(ic_tag_rdata_o[w]));
    end

    line_rdata_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
      ic_data_rdata_o[w] === exp_line_rdata[w])
    else begin
      error_count++;
      $display("Mismatch in %s: way %0d line expected %h, got %h",
               test_name, w, $sampled(exp_line_rdata[w]), $sampled(ic_data_rdata_o[w]));
    end
  end

  ////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////

  // Same access on the tag and data bank of one way
  task automatic drive_access(input int way, input logic write, input ic_index_t addr);
    @(negedge clk_i);
    ic_tag_req_i         = '0;
    ic_data_req_i        = '0;
    ic_tag_req_i[way]    = 1'b1;
    ic_data_req_i[way]   = 1'b1;
    ic_tag_write_i       = write;
    ic_data_write_i      = write;
    ic_tag_addr_i        = addr;
    ic_data_addr_i       = addr;
    ic_tag_wdata_i       = ic_tag_t'($urandom);
    ic_data_wdata_i      = {$urandom, $urandom};
    if (!write) read_count++;
  endtask

  task automatic drive_random_access();
    drive_access($urandom_range(0, `IC_NUM_WAYS - 1), 1'($urandom_range(0, 1)),
                 ic_index_t'($urandom));
  endtask

  task automatic drive_idle();
    @(negedge clk_i);
    ic_tag_req_i    = '0;
    ic_data_req_i   = '0;
    ic_tag_write_i  = 1'b0;
    ic_data_write_i = 1'b0;
  endtask

  task automatic await_key_state(input logic req_level);
    int cycles;
    cycles = 0;
    while (!(scramble_req_o === req_level && ic_scr_key_valid_o === !req_level)
           && cycles < wait_limit) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!(scramble_req_o === req_level && ic_scr_key_valid_o === !req_level)) begin
      $display("Timeout: key request flags did not settle within %0d cycles in %s",
               wait_limit, test_name);
      $display("TESTS FAILED");
      $finish;
    end
  endtask

  task automatic rekey();
    int hold;
    hold = $urandom_range(2, 8);
    test_name = "key_request";
    @(negedge clk_i);
    ic_scr_key_req_i = 1'b1;
    @(negedge clk_i);
    ic_scr_key_req_i = 1'b0;
    await_key_state(1'b1);
    // Bank traffic while the key source is silent must be dropped
    test_name = "key_invalid";
    repeat (hold) drive_random_access();
    drive_idle();
    test_name = "key_request";
    scramble_key_valid_i = 1'b1;
    scramble_key_i       = $urandom;
    scramble_nonce_i     = scr_nonce_t'($urandom);
    @(negedge clk_i);
    scramble_key_valid_i = 1'b0;
    await_key_state(1'b0);
    rekey_count++;
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    void'($urandom(41112));
    error_count = 0;
    read_count = 0;
    rekey_count = 0;
    test_name = "reset";
    rst_ni = 1'b0;
    test_en_i = 1'b0;
    core_busy_i = `MUBI_OFF;
    debug_req_i = 1'b0;
    irq_pending_i = 1'b0;
    irq_nm_i = 1'b0;
    ic_scr_key_req_i = 1'b0;
    scramble_key_valid_i = 1'b0;
    scramble_key_i = '0;
    scramble_nonce_i = '0;
    ic_tag_req_i = '0;
    ic_tag_write_i = 1'b0;
    ic_tag_addr_i = '0;
    ic_tag_wdata_i = '0;
    ic_data_req_i = '0;
    ic_data_write_i = 1'b0;
    ic_data_addr_i = '0;
    ic_data_wdata_i = '0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    test_name = "after_reset";
    repeat (3) @(negedge clk_i);

    // Every entry written, so no read after rekeying hits an empty slot
    test_name = "fill";
    for (int w = 0; w < `IC_NUM_WAYS; w++) begin
      for (int a = 0; a < `IC_NUM_LINES; a++) drive_access(w, 1'b1, ic_index_t'(a));
    end
    test_name = "round_trip";
    repeat (80) drive_random_access();
    drive_idle();

    for (int r = 0; r < 2; r++) begin
      rekey();
      test_name = "after_rekey";
      for (int w = 0; w < `IC_NUM_WAYS; w++) begin
        for (int a = 0; a < `IC_NUM_LINES; a++) drive_access(w, 1'b0, ic_index_t'(a));
      end
      repeat (30) drive_random_access();
      drive_idle();
    end

    test_name = "clock_control";
    core_busy_i = `MUBI_ON;
    repeat ($urandom_range(3, 6)) @(negedge clk_i);
    core_busy_i = `MUBI_OFF;
    repeat (4) @(negedge clk_i);
    debug_req_i = 1'b1;
    repeat (3) @(negedge clk_i);
    debug_req_i = 1'b0;
    irq_pending_i = 1'b1;
    repeat (3) @(negedge clk_i);
    irq_pending_i = 1'b0;
    irq_nm_i = 1'b1;
    repeat (3) @(negedge clk_i);
    irq_nm_i = 1'b0;
    repeat (4) @(negedge clk_i);
    test_en_i = 1'b1;
    repeat (4) @(negedge clk_i);
    test_en_i = 1'b0;
    repeat (3) @(negedge clk_i);

    $display("Summary: %0d errors, %0d reads, %0d rekeys", error_count, read_count, rekey_count);
    if (error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/core_clock_ctrl.sv */
// Main clock control
// Registered busy flag and wake-up sources enable a latch-based clock gate

`default_nettype none

`include "ic_mem_settings.svh"

module core_clock_ctrl import ic_mem_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,

  // Forces the gate open in test mode
  input  logic       test_en_i,

  input  busy_mubi_t core_busy_i,
  input  logic       debug_req_i,
  input  logic       irq_pending_i,
  input  logic       irq_nm_i,

  output logic       core_clk_o,
  output logic       core_sleep_o
);

  busy_mubi_t busy_q;
  logic       clock_en;
  logic       en_latch;

  ////////////////////////////////////////
  // Busy flag and enable
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= `MUBI_OFF;
    end else begin
      busy_q <= core_busy_i;
    end
  end

  // Any pattern but "off" keeps the core running
  assign clock_en = (busy_q != `MUBI_OFF) | debug_req_i | irq_pending_i | irq_nm_i;

  assign core_sleep_o = ~clock_en;

  ////////////////////////////////////////
  // Clock gate
  ////////////////////////////////////////

  // Transparent while the clock is low, so no glitch on the gated clock
  always_latch begin
    if (!clk_i) begin
      en_latch = clock_en | test_en_i;
    end
  end

  assign core_clk_o = clk_i & en_latch;

  // Core side must only ever drive the two legal encodings
  busy_legal_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    busy_q == `MUBI_ON || busy_q == `MUBI_OFF);

endmodule

`default_nettype wire

/* verilog/ic_mem_pkg.sv */
// Instruction-cache memory package
// Index, payload, scramble and busy types shared by the memory blocks

`default_nettype none

`include "ic_mem_settings.svh"

package ic_mem_pkg;

  ////////////////////////////////////////
  // Cache payloads
  ////////////////////////////////////////

  typedef logic [`IC_INDEX_W-1:0] ic_index_t;
  typedef logic [`IC_TAG_W-1:0]   ic_tag_t;
  // Two 32-bit beats per line
  typedef logic [`IC_LINE_W-1:0]  ic_line_t;

  ////////////////////////////////////////
  // Scrambling and clock control
  ////////////////////////////////////////

  typedef logic [`IC_SCR_KEY_W-1:0]   scr_key_t;
  typedef logic [`IC_SCR_NONCE_W-1:0] scr_nonce_t;
  typedef logic [3:0]                 busy_mubi_t;

endpackage

`default_nettype wire

/* verilog/ic_mem_settings.svh */
// Instruction-cache memory settings
// Cache geometry, scramble key sizes, reset key and nonce, busy encodings
`ifndef IC_MEM_SETTINGS_SVH
`define IC_MEM_SETTINGS_SVH

// Cache geometry
`define IC_NUM_WAYS  2
`define IC_NUM_LINES 16
`define IC_INDEX_W   4
`define IC_TAG_W     12
`define IC_LINE_W    64

// Scrambling
`define IC_SCR_KEY_W         32
`define IC_SCR_NONCE_W       `IC_INDEX_W
`define IC_SCR_KEY_DEFAULT   32'h9d3a_51c7
`define IC_SCR_NONCE_DEFAULT 4'ha

// Multi-bit busy flag encodings
`define MUBI_ON  4'b0101
`define MUBI_OFF 4'b1010

`endif

/* verilog/ic_mem_top.sv */
// Instruction-cache memory top level
// Key manager, main clock control and scrambled tag and data banks per way

`default_nettype none

`include "ic_mem_settings.svh"

module ic_mem_top import ic_mem_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_ni,

  input  logic                          test_en_i,

  // Clock control
  input  busy_mubi_t                    core_busy_i,
  input  logic                          debug_req_i,
  input  logic                          irq_pending_i,
  input  logic                          irq_nm_i,
  output logic                          core_clk_o,
  output logic                          core_sleep_o,

  // Scrambling
  input  logic                          ic_scr_key_req_i,
  input  logic                          scramble_key_valid_i,
  input  scr_key_t                      scramble_key_i,
  input  scr_nonce_t                    scramble_nonce_i,
  output logic                          scramble_req_o,
  output logic                          ic_scr_key_valid_o,

  // Tag banks
  input  logic [`IC_NUM_WAYS-1:0]       ic_tag_req_i,
  input  logic                          ic_tag_write_i,
  input  ic_index_t                     ic_tag_addr_i,
  input  ic_tag_t                       ic_tag_wdata_i,
  output ic_tag_t  [`IC_NUM_WAYS-1:0]   ic_tag_rdata_o,

  // Data banks
  input  logic [`IC_NUM_WAYS-1:0]       ic_data_req_i,
  input  logic                          ic_data_write_i,
  input  ic_index_t                     ic_data_addr_i,
  input  ic_line_t                      ic_data_wdata_i,
  output ic_line_t [`IC_NUM_WAYS-1:0]   ic_data_rdata_o
);

  scr_key_t   scr_key;
  scr_nonce_t scr_nonce;

  ////////////////////////////////////////
  // Main clock control
  ////////////////////////////////////////

  core_clock_ctrl u_clock_ctrl (
    .clk_i,
    .rst_ni,
    .test_en_i,
    .core_busy_i,
    .debug_req_i,
    .irq_pending_i,
    .irq_nm_i,
    .core_clk_o,
    .core_sleep_o
  );

  ////////////////////////////////////////
  // Scramble key
  ////////////////////////////////////////

  ic_scr_key_mgr u_key_mgr (
    .clk_i,
    .rst_ni,
    .ic_scr_key_req_i,
    .scramble_key_valid_i,
    .scramble_key_i,
    .scramble_nonce_i,
    .scramble_req_o,
    .key_valid_o   (ic_scr_key_valid_o),
    .key_o         (scr_key),
    .nonce_o       (scr_nonce)
  );

  ////////////////////////////////////////
  // RAM banks
  ////////////////////////////////////////

  // Every bank shares the same key and nonce
  for (genvar way = 0; way < `IC_NUM_WAYS; way++) begin : g_ways
    ic_ram_bank #(
      .payload_t (ic_tag_t)
    ) u_tag_bank (
      .clk_i,
      .rst_ni,
      .req_i       (ic_tag_req_i[way]),
      .write_i     (ic_tag_write_i),
      .addr_i      (ic_tag_addr_i),
      .wdata_i     (ic_tag_wdata_i),
      .key_valid_i (ic_scr_key_valid_o),
      .key_i       (scr_key),
      .nonce_i     (scr_nonce),
      .rdata_o     (ic_tag_rdata_o[way])
    );

    ic_ram_bank #(
      .payload_t (ic_line_t)
    ) u_data_bank (
      .clk_i,
      .rst_ni,
      .req_i       (ic_data_req_i[way]),
      .write_i     (ic_data_write_i),
      .addr_i      (ic_data_addr_i),
      .wdata_i     (ic_data_wdata_i),
      .key_valid_i (ic_scr_key_valid_o),
      .key_i       (scr_key),
      .nonce_i     (scr_nonce),
      .rdata_o     (ic_data_rdata_o[way])
    );
  end

endmodule

`default_nettype wire

/* verilog/ic_ram_bank.sv */
// Scrambled single-port RAM bank
// Data is XOR-ed with the repeated key, the index with the nonce
// One-cycle read latency, accesses ignored while the key is invalid

`default_nettype none

`include "ic_mem_settings.svh"

module ic_ram_bank import ic_mem_pkg::*; #(
  parameter type payload_t = logic [31:0]
) (
  input  logic       clk_i,
  input  logic       rst_ni,

  input  logic       req_i,
  input  logic       write_i,
  input  ic_index_t  addr_i,
  input  payload_t   wdata_i,

  input  logic       key_valid_i,
  input  scr_key_t   key_i,
  input  scr_nonce_t nonce_i,

  output payload_t   rdata_o
);

  localparam int unsigned payload_w = $bits(payload_t);
  localparam int unsigned key_w     = $bits(scr_key_t);
  localparam int unsigned key_reps  = (payload_w + key_w - 1) / key_w;

  logic [key_reps*key_w-1:0] key_rep;
  payload_t                  key_stream;
  ic_index_t                 phys_addr;
  logic                      access;

  payload_t mem_q [`IC_NUM_LINES];

  ////////////////////////////////////////
  // Scrambling
  ////////////////////////////////////////

  // Key repeated, then cut to the payload width
  assign key_rep    = {key_reps{key_i}};
  assign key_stream = key_rep[payload_w-1:0];

  assign phys_addr = addr_i ^ nonce_i;
  assign access    = req_i & key_valid_i;

  ////////////////////////////////////////
  // Storage and read port
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (access && write_i) begin
      mem_q[phys_addr] <= wdata_i ^ key_stream;
    end
  end

  // Read data holds between reads
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (access && !write_i) begin
      rdata_o <= mem_q[phys_addr] ^ key_stream;
    end
  end

  // Controller and key manager must drive clean levels
  req_known_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown({req_i, key_valid_i}));

  access_known_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    access |-> !$isunknown({write_i, addr_i, nonce_i}));

endmodule

`default_nettype wire

/* verilog/ic_scr_key_mgr.sv */
// Scramble key manager
// Requests a fresh key on cache invalidation and holds key, nonce and key valid

`default_nettype none

`include "ic_mem_settings.svh"

module ic_scr_key_mgr import ic_mem_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,

  // Invalidate pulse from the cache controller
  input  logic       ic_scr_key_req_i,

  // External key source
  input  logic       scramble_key_valid_i,
  input  scr_key_t   scramble_key_i,
  input  scr_nonce_t scramble_nonce_i,
  output logic       scramble_req_o,

  // Towards the RAM banks
  output logic       key_valid_o,
  output scr_key_t   key_o,
  output scr_nonce_t nonce_o
);

  logic req_d, req_q;
  logic valid_d, valid_q;

  ////////////////////////////////////////
  // Request and valid flags
  ////////////////////////////////////////

  // Request holds until the key source answers
  assign req_d = req_q ? ~scramble_key_valid_i : ic_scr_key_req_i;

  // Key goes invalid on invalidate, valid again with the answer
  assign valid_d = req_q            ? scramble_key_valid_i :
                   ic_scr_key_req_i ? 1'b0                 :
                                      valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q   <= 1'b0;
      valid_q <= 1'b1;
    end else begin
      req_q   <= req_d;
      valid_q <= valid_d;
    end
  end

  // Key and nonce follow every valid strobe
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_o   <= `IC_SCR_KEY_DEFAULT;
      nonce_o <= `IC_SCR_NONCE_DEFAULT;
    end else if (scramble_key_valid_i) begin
      key_o   <= scramble_key_i;
      nonce_o <= scramble_nonce_i;
    end
  end

  assign scramble_req_o = req_q;
  assign key_valid_o    = valid_q;

  // Banks never see a valid key while a new one is outstanding
  req_excludes_valid_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    scramble_req_o |-> !key_valid_o);

  // Key valid only returns as the request completes
  valid_rise_ends_req_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(key_valid_o) |-> $fell(scramble_req_o));

endmodule

`default_nettype wire
